// ==== sim.f ====
video_cfg_pkg.sv
host_cmd_decoder.sv
viewport_calc.sv
audio_mixer.sv
video_cfg_top.sv
tb_clock_gen.sv
video_cfg_tb.sv

// ==== Makefile ====
TOP = video_cfg_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "STATUS: PASS"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f sim.f

clean:
	rm -rf obj_dir

// ==== video_cfg_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench for the video configuration top level.
// Stimulus table with expected windows and samples, four-phase host
// bus tasks, window and sample compare tasks and the final report.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module video_cfg_tb;

	localparam int N_ROWS        = 10;
	localparam int N_WORDS       = 39;
	localparam int ACK_TIMEOUT   = 16;
	localparam int DROP_TIMEOUT  = 8;
	localparam int VALID_TIMEOUT = 100;
	localparam int RESET_TIMEOUT = 10;
	// Mixer pipeline plus the glitch filter compare
	localparam int MIX_SETTLE    = 8;

	localparam video_cfg_pkg::view_window_t WIN_FULL = '{12'd0, 12'd1919, 12'd0, 12'd1079};
	localparam video_cfg_pkg::view_window_t WIN_43   = '{12'd240, 12'd1679, 12'd0, 12'd1079};
	localparam video_cfg_pkg::view_window_t WIN_169  = '{12'd320, 12'd1599, 12'd180, 12'd899};
	localparam video_cfg_pkg::view_window_t WIN_FB   = '{12'd10, 12'd500, 12'd20, 12'd400};

	typedef struct packed {
		int                          n_words;
		int                          abort_at;
		logic                        upd;
		logic                        is_signed;
		video_cfg_pkg::aspect_t      arx;
		video_cfg_pkg::aspect_t      ary;
		video_cfg_pkg::sample_t      core_in;
		video_cfg_pkg::sample_t      linux_in;
		video_cfg_pkg::sample_t      exp_out;
		video_cfg_pkg::view_window_t exp_view;
	} test_row_t;

	// Host words of all tests in order, command word first
	video_cfg_pkg::word_t host_words [N_WORDS] = '{
		16'h0020, 16'd1920, 16'd0, 16'd0, 16'd0, 16'd1080,
		16'h0020, 16'd1920, 16'd0, 16'd0, 16'd0, 16'd1080,
		16'h0027, 16'd720,
		16'h002F, 16'h8000, 16'd0, 16'd0, 16'd0, 16'd0, 16'd10, 16'd500, 16'd20, 16'd400,
		16'h002F, 16'h0000,
		16'h0026, 16'h0002,
		16'h0026, 16'h0010,
		16'h0026, 16'h0000,
		16'h0055, 16'h1234, 16'h5678,
		16'h0055, 16'h1111, 16'h0026, 16'h0001
	};

	// words, abort index, update, signed, ARX, ARY, core, linux, sample, window
	test_row_t rows [N_ROWS] = '{
		'{6,  0, 1'b1, 1'b1, 8'd0,  8'd0, 16'h1234, 16'h0010, 16'h1244, WIN_FULL},
		'{6,  0, 1'b1, 1'b1, 8'd4,  8'd3, 16'h4000, 16'h4000, 16'h7FFF, WIN_43},
		'{2,  0, 1'b1, 1'b1, 8'd16, 8'd9, 16'h8000, 16'h8000, 16'h8000, WIN_169},
		'{10, 0, 1'b1, 1'b1, 8'd16, 8'd9, 16'hF000, 16'h0100, 16'hF100, WIN_FB},
		'{2,  0, 1'b1, 1'b1, 8'd16, 8'd9, 16'h0000, 16'h0000, 16'h0000, WIN_169},
		'{2,  0, 1'b0, 1'b1, 8'd16, 8'd9, 16'h1000, 16'h0000, 16'h0400, WIN_169},
		'{2,  0, 1'b0, 1'b1, 8'd16, 8'd9, 16'h1000, 16'h0000, 16'h0000, WIN_169},
		'{2,  0, 1'b0, 1'b0, 8'd16, 8'd9, 16'h8000, 16'h0000, 16'h4000, WIN_169},
		'{3,  0, 1'b0, 1'b0, 8'd16, 8'd9, 16'hFFFE, 16'h0001, 16'h7FFF, WIN_169},
		'{4,  2, 1'b0, 1'b1, 8'd16, 8'd9, 16'h1000, 16'h0000, 16'h0800, WIN_169}
	};

	string names [N_ROWS] = '{"full frame", "aspect 4:3", "vset 720 16:9",
		"fb window on", "fb window off", "attenuation 2", "mute",
		"unsigned core", "unknown command", "aborted then volume"};

	logic                        clk;
	logic                        resetd;
	logic                        io_sel;
	logic                        io_req;
	video_cfg_pkg::word_t        io_din;
	logic                        io_ack;
	video_cfg_pkg::aspect_t      arx;
	video_cfg_pkg::aspect_t      ary;
	logic                        audio_signed;
	video_cfg_pkg::sample_t      core_smp;
	video_cfg_pkg::sample_t      linux_smp;
	video_cfg_pkg::view_window_t view;
	logic                        view_valid;
	video_cfg_pkg::sample_t      audio_l;
	video_cfg_pkg::sample_t      audio_r;
	int                          err_count;
	int                          fail_tests;

	tb_clock_gen clock_inst (
		.o_clk    (clk),
		.o_resetd (resetd)
	);

	// Both channels get the same samples
	video_cfg_top video_cfg_top_inst (
		.clk            (clk),
		.resetd         (resetd),
		.i_io_sel       (io_sel),
		.i_io_req       (io_req),
		.i_io_din       (io_din),
		.o_io_ack       (io_ack),
		.i_arx          (arx),
		.i_ary          (ary),
		.i_audio_signed (audio_signed),
		.i_core_l       (core_smp),
		.i_core_r       (core_smp),
		.i_linux_l      (linux_smp),
		.i_linux_r      (linux_smp),
		.o_view         (view),
		.o_view_valid   (view_valid),
		.o_audio_l      (audio_l),
		.o_audio_r      (audio_r)
	);

	//////////////////////////  Compare tasks  /////////////////////////////

	task automatic check_window(input int r, input video_cfg_pkg::view_window_t got,
	                            input video_cfg_pkg::view_window_t exp);
		if (got !== exp) begin
			$display("ERROR @ %0t: test %0d window %0d-%0d %0d-%0d, expected %0d-%0d %0d-%0d",
			         $time, r, got.hmin, got.hmax, got.vmin, got.vmax,
			         exp.hmin, exp.hmax, exp.vmin, exp.vmax);
			err_count++;
		end
	endtask

	task automatic check_sample(input int r, input string chan,
	                            input video_cfg_pkg::sample_t got,
	                            input video_cfg_pkg::sample_t exp);
		if (got !== exp) begin
			$display("ERROR @ %0t: test %0d %s sample %h, expected %h",
			         $time, r, chan, got, exp);
			err_count++;
		end
	endtask

	//////////////////////////  Host bus  //////////////////////////////////

	// One four-phase handshake
	task automatic send_word(input video_cfg_pkg::word_t w);
		int n;
		@(posedge clk);
		io_din <= w;
		io_req <= 1'b1;
		n = 0;
		@(negedge clk);
		while (io_ack !== 1'b1 && n < ACK_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (io_ack !== 1'b1) begin
			$display("Host word %h got no acknowledge from DUT", w);
			err_count++;
		end
		@(posedge clk);
		io_req <= 1'b0;
		n = 0;
		@(negedge clk);
		while (io_ack !== 1'b0 && n < ACK_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (io_ack !== 1'b0) begin
			$display("DUT kept acknowledge high after request dropped for word %h", w);
			err_count++;
		end
	endtask

	task automatic run_transfer(input int first, input int count, input int abort_at);
		@(posedge clk);
		io_sel <= 1'b1;
		for (int i = 0; i < count; i++) begin
			if (abort_at != 0 && i == abort_at) begin
				// One cycle of select low abandons the command
				@(posedge clk);
				io_sel <= 1'b0;
				@(posedge clk);
				io_sel <= 1'b1;
			end
			send_word(host_words[first + i]);
		end
		@(posedge clk);
		io_sel <= 1'b0;
	endtask

	task automatic wait_view_update(input int r);
		int n;
		video_cfg_pkg::calc_state_e st;
		n = 0;
		@(negedge clk);
		while (view_valid !== 1'b0 && n < DROP_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (view_valid !== 1'b0) begin
			$display("Test %0d: viewport result stayed valid after the update", r);
			err_count++;
		end
		n = 0;
		while (view_valid !== 1'b1 && n < VALID_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (view_valid !== 1'b1) begin
			st = video_cfg_top_inst.viewport_inst.state;
			$display("Test %0d: viewport result never became valid, FSM in %s", r, st.name());
			err_count++;
		end
	endtask

	//////////////////////////  Test sequence  /////////////////////////////

	initial begin
		int n;
		int first;
		int errs_before;
		io_sel       = 1'b0;
		io_req       = 1'b0;
		io_din       = '0;
		arx          = '0;
		ary          = '0;
		audio_signed = 1'b1;
		core_smp     = '0;
		linux_smp    = '0;
		err_count    = 0;
		fail_tests   = 0;
		first        = 0;
		n            = 0;
		while (resetd !== 1'b0 && n < RESET_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (resetd !== 1'b0) begin
			$display("Reset was never released");
			err_count++;
		end
		for (int r = 0; r < N_ROWS; r++) begin
			errs_before = err_count;
			@(posedge clk);
			arx          <= rows[r].arx;
			ary          <= rows[r].ary;
			audio_signed <= rows[r].is_signed;
			core_smp     <= rows[r].core_in;
			linux_smp    <= rows[r].linux_in;
			run_transfer(first, rows[r].n_words, rows[r].abort_at);
			if (rows[r].upd)
				wait_view_update(r);
			repeat (MIX_SETTLE) @(negedge clk);
			if (view_valid !== 1'b1) begin
				$display("Test %0d: viewport result not valid when checked", r);
				err_count++;
			end
			check_window(r, view, rows[r].exp_view);
			check_sample(r, "left", audio_l, rows[r].exp_out);
			check_sample(r, "right", audio_r, rows[r].exp_out);
			if (err_count != errs_before)
				fail_tests++;
			$display("test %0d %s: %s", r, names[r],
			         (err_count == errs_before) ? "passed" : "FAILED");
			first = first + rows[r].n_words;
		end
		$display("%0d tests, %0d passed, %0d failed, %0d errors",
		         N_ROWS, N_ROWS - fail_tests, fail_tests, err_count);
		if (err_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// ==== tb_clock_gen.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench clock and reset generator.
// 40 ns clock, synchronous active high reset held for three cycles.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_clock_gen #(
	parameter int HALF_PERIOD  = 20,
	parameter int RESET_CYCLES = 3
) (
	output logic o_clk,
	output logic o_resetd
);

	initial begin
		o_clk = 1'b0;
		forever #(HALF_PERIOD) o_clk = ~o_clk;
	end

	// Released on a rising edge so the DUT sees a clean synchronous reset
	initial begin
		o_resetd = 1'b1;
		repeat (RESET_CYCLES) @(posedge o_clk);
		o_resetd <= 1'b0;
	end

endmodule

// ==== video_cfg_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Top level of the video configuration and audio path.
// Host command decoder, viewport calculator and two audio mixers.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module video_cfg_top #(
	parameter int DEFAULT_WIDTH  = 1920,
	parameter int DEFAULT_HEIGHT = 1080
) (
	input  logic                        clk,
	input  logic                        resetd,

	// Host bus
	input  logic                        i_io_sel,
	input  logic                        i_io_req,
	input  video_cfg_pkg::word_t        i_io_din,
	output logic                        o_io_ack,

	// Aspect ratio from the core
	input  video_cfg_pkg::aspect_t      i_arx,
	input  video_cfg_pkg::aspect_t      i_ary,

	// Audio sources
	input  logic                        i_audio_signed,
	input  video_cfg_pkg::sample_t      i_core_l,
	input  video_cfg_pkg::sample_t      i_core_r,
	input  video_cfg_pkg::sample_t      i_linux_l,
	input  video_cfg_pkg::sample_t      i_linux_r,

	output video_cfg_pkg::view_window_t o_view,
	output logic                        o_view_valid,
	output video_cfg_pkg::sample_t      o_audio_l,
	output video_cfg_pkg::sample_t      o_audio_r
);

	video_cfg_pkg::video_cfg_t cfg;
	logic                      cfg_update;
	video_cfg_pkg::att_t       att;

	host_cmd_decoder #(
		.DEFAULT_WIDTH  (DEFAULT_WIDTH),
		.DEFAULT_HEIGHT (DEFAULT_HEIGHT)
	) decoder_inst (
		.clk          (clk),
		.resetd       (resetd),
		.i_io_sel     (i_io_sel),
		.i_io_req     (i_io_req),
		.i_io_din     (i_io_din),
		.o_io_ack     (o_io_ack),
		.o_cfg        (cfg),
		.o_cfg_update (cfg_update),
		.o_att        (att)
	);

	viewport_calc viewport_inst (
		.clk          (clk),
		.resetd       (resetd),
		.i_cfg        (cfg),
		.i_cfg_update (cfg_update),
		.i_arx        (i_arx),
		.i_ary        (i_ary),
		.o_view       (o_view),
		.o_view_valid (o_view_valid)
	);

	// Left and right share format and attenuation
	audio_mixer mixer_l_inst (
		.clk         (clk),
		.resetd      (resetd),
		.i_is_signed (i_audio_signed),
		.i_att       (att),
		.i_core      (i_core_l),
		.i_linux     (i_linux_l),
		.o_out       (o_audio_l)
	);

	audio_mixer mixer_r_inst (
		.clk         (clk),
		.resetd      (resetd),
		.i_is_signed (i_audio_signed),
		.i_att       (att),
		.i_core      (i_core_r),
		.i_linux     (i_linux_r),
		.o_out       (o_audio_r)
	);

endmodule

// ==== audio_mixer.sv ====
////////////////////////////////////////////////////////////////////////////
// Audio mixer, one channel.
// Glitch filter on core audio, core/Linux mix, shift attenuation
// with mute and saturation to 16 bits. Six cycles of latency.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module audio_mixer (
	input  logic                   clk,
	input  logic                   resetd,

	input  logic                   i_is_signed,
	input  video_cfg_pkg::att_t    i_att,
	input  video_cfg_pkg::sample_t i_core,
	input  video_cfg_pkg::sample_t i_linux,

	output video_cfg_pkg::sample_t o_out
);

	// One bit of headroom over a sample
	typedef logic signed [video_cfg_pkg::SAMPLE_W:0] mix_t;

	video_cfg_pkg::sample_t core_d1;
	video_cfg_pkg::sample_t core_d2;
	video_cfg_pkg::sample_t core_d3;
	video_cfg_pkg::sample_t core_ok;
	mix_t                   mix_sum;
	mix_t                   mix_att;

	mix_t                   core_wide;
	mix_t                   linux_wide;

	// Unsigned core becomes a half-scale positive value
	assign core_wide  = i_is_signed ? mix_t'({core_ok[15], core_ok})
	                                : mix_t'({2'b00, core_ok[15:1]});
	assign linux_wide = mix_t'({i_linux[15], i_linux});

	always_ff @(posedge clk) begin
		if (resetd) begin
			core_d1 <= '0;
			core_d2 <= '0;
			core_d3 <= '0;
			core_ok <= '0;
			mix_sum <= '0;
			mix_att <= '0;
			o_out   <= '0;
		end else begin
			// Stages 1 to 3, glitch filter
			core_d1 <= i_core;
			core_d2 <= core_d1;
			core_d3 <= core_d2;
			if (core_d2 == core_d3)
				core_ok <= core_d2;

			// Stage 4
			mix_sum <= core_wide + linux_wide;

			// Stage 5, mute or shift down
			if (i_att[4])
				mix_att <= '0;
			else
				mix_att <= mix_sum >>> i_att[3:0];

			// Stage 6, clamp when bits 16 and 15 disagree
			o_out <= (mix_att[16] ^ mix_att[15]) ? {mix_att[16], {15{mix_att[15]}}}
			                                     : mix_att[15:0];
		end
	end

endmodule

// ==== viewport_calc.sv ====
////////////////////////////////////////////////////////////////////////////
// Viewport calculator.
// Aspect-ratio window FSM with one shared restoring divider,
// framebuffer override and the registered window result.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module viewport_calc (
	input  logic                        clk,
	input  logic                        resetd,

	input  video_cfg_pkg::video_cfg_t   i_cfg,
	input  logic                        i_cfg_update,
	input  video_cfg_pkg::aspect_t      i_arx,
	input  video_cfg_pkg::aspect_t      i_ary,

	output video_cfg_pkg::view_window_t o_view,
	output logic                        o_view_valid
);

	// Product of a 12-bit size and an 8-bit aspect term
	localparam int QUOT_W = 20;
	typedef logic [QUOT_W-1:0] quot_t;
	localparam logic [4:0] LAST_BIT = 5'(QUOT_W - 1);

	video_cfg_pkg::calc_state_e state;
	video_cfg_pkg::video_cfg_t  cfg_q;
	video_cfg_pkg::aspect_t     arx_q;
	video_cfg_pkg::aspect_t     ary_q;
	video_cfg_pkg::dim_t        video_w;
	video_cfg_pkg::dim_t        video_h;
	quot_t                      wcalc;
	quot_t                      hcalc;

	// Divider registers, dividend shifts out of div_quo as quotient shifts in
	quot_t                      div_quo;
	video_cfg_pkg::aspect_t     div_rem;
	logic [4:0]                 div_cnt;

	video_cfg_pkg::aspect_t     div_den;
	logic [8:0]                 div_shift;
	logic                       div_bit;
	video_cfg_pkg::aspect_t     div_rem_next;
	quot_t                      div_next;
	video_cfg_pkg::dim_t        ref_h;
	video_cfg_pkg::dim_t        h_off;
	video_cfg_pkg::dim_t        v_off;
	logic                       no_aspect;

	/////////////////////////  Divider step  ///////////////////////////////

	always_comb begin
		div_den      = (state == video_cfg_pkg::DIV_W) ? ary_q : arx_q;
		div_shift    = {div_rem, div_quo[QUOT_W-1]};
		div_bit      = div_shift >= {1'b0, div_den};
		div_rem_next = div_bit ? video_cfg_pkg::aspect_t'(div_shift - {1'b0, div_den})
		                       : div_shift[7:0];
		div_next     = {div_quo[QUOT_W-2:0], div_bit};
	end

	// Height used for the width estimate
	assign ref_h     = (i_cfg.vset != '0) ? i_cfg.vset : i_cfg.height;
	assign no_aspect = (i_arx == '0) || (i_ary == '0);

	// Centring offsets
	assign h_off = (cfg_q.width - video_w) >> 1;
	assign v_off = (cfg_q.height - video_h) >> 1;

	/////////////////////////  Window FSM  /////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			state        <= video_cfg_pkg::IDLE;
			o_view_valid <= 1'b0;
			div_cnt      <= '0;
		end else if (i_cfg_update) begin
			// Any update restarts from a fresh snapshot
			cfg_q        <= i_cfg;
			arx_q        <= i_arx;
			ary_q        <= i_ary;
			o_view_valid <= 1'b0;
			video_w      <= i_cfg.width;
			video_h      <= i_cfg.height;
			div_quo      <= quot_t'(ref_h) * quot_t'(i_arx);
			div_rem      <= '0;
			div_cnt      <= LAST_BIT;
			if (i_cfg.fb_en || no_aspect)
				state <= video_cfg_pkg::PLACE;
			else
				state <= video_cfg_pkg::DIV_W;
		end else begin
			case (state)
				video_cfg_pkg::DIV_W: begin
					div_rem <= div_rem_next;
					div_quo <= div_next;
					div_cnt <= div_cnt - 1'b1;
					if (div_cnt == '0) begin
						// wcalc done, start width * ARY / ARX
						wcalc   <= div_next;
						div_quo <= quot_t'(cfg_q.width) * quot_t'(ary_q);
						div_rem <= '0;
						div_cnt <= LAST_BIT;
						state   <= video_cfg_pkg::DIV_H;
					end
				end
				video_cfg_pkg::DIV_H: begin
					div_rem <= div_rem_next;
					div_quo <= div_next;
					div_cnt <= div_cnt - 1'b1;
					if (div_cnt == '0) begin
						hcalc <= div_next;
						state <= video_cfg_pkg::CLIP;
					end
				end
				video_cfg_pkg::CLIP: begin
					// VSET forces the height and leaves the width unclipped
					if (cfg_q.vset != '0) begin
						video_w <= wcalc[video_cfg_pkg::DIM_W-1:0];
						video_h <= cfg_q.vset;
					end else begin
						video_w <= (wcalc > quot_t'(cfg_q.width)) ? cfg_q.width
						                                          : wcalc[11:0];
						video_h <= (hcalc > quot_t'(cfg_q.height)) ? cfg_q.height
						                                           : hcalc[11:0];
					end
					state <= video_cfg_pkg::PLACE;
				end
				video_cfg_pkg::PLACE: begin
					if (cfg_q.fb_en) begin
						o_view <= cfg_q.fb_window;
					end else begin
						o_view.hmin <= h_off;
						o_view.hmax <= h_off + video_w - 1'b1;
						o_view.vmin <= v_off;
						o_view.vmax <= v_off + video_h - 1'b1;
					end
					o_view_valid <= 1'b1;
					state        <= video_cfg_pkg::IDLE;
				end
				default: ;
			endcase
		end
	end

	/////////////////////////  Assertions  /////////////////////////////////

	// Holds for any window the host can sensibly request
	a_window_order: assert property (
		@(posedge clk) disable iff (resetd)
		o_view_valid |-> (o_view.hmin <= o_view.hmax)
	) else $error("valid window with hmin above hmax");

endmodule

// ==== host_cmd_decoder.sv ====
////////////////////////////////////////////////////////////////////////////
// Host command decoder.
// Four-phase req/ack slave, command and data word sequencing,
// video size, VSET, framebuffer window and volume registers.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module host_cmd_decoder #(
	parameter int DEFAULT_WIDTH  = 1920,
	parameter int DEFAULT_HEIGHT = 1080
) (
	input  logic                     clk,
	input  logic                     resetd,

	input  logic                     i_io_sel,
	input  logic                     i_io_req,
	input  video_cfg_pkg::word_t     i_io_din,
	output logic                     o_io_ack,

	output video_cfg_pkg::video_cfg_t o_cfg,
	output logic                     o_cfg_update,
	output video_cfg_pkg::att_t      o_att
);

	// Index of the data word within a command
	typedef logic [3:0] word_idx_t;

	logic                  has_cmd;
	video_cfg_pkg::cmd_t   cmd;
	word_idx_t             word_cnt;
	logic                  sel_d;

	logic                  strobe;
	logic                  sel_fall;
	logic                  cmd_is_video;
	video_cfg_pkg::dim_t   din_dim;

	// New word on the bus, first cycle of req with ack still low
	assign strobe   = i_io_req & ~o_io_ack;
	assign sel_fall = sel_d & ~i_io_sel;
	assign din_dim  = i_io_din[video_cfg_pkg::DIM_W-1:0];

	// Commands whose end triggers a viewport recalculation
	assign cmd_is_video = (cmd == video_cfg_pkg::CMD_VIDEO_SIZE) ||
	                      (cmd == video_cfg_pkg::CMD_VSET) ||
	                      (cmd == video_cfg_pkg::CMD_FB_WINDOW);

	/////////////////////////  Handshake  //////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			o_io_ack     <= 1'b0;
			sel_d        <= 1'b0;
			o_cfg_update <= 1'b0;
		end else begin
			// Ack follows req one cycle later in both directions
			o_io_ack     <= i_io_req;
			sel_d        <= i_io_sel;
			o_cfg_update <= sel_fall & has_cmd & cmd_is_video;
		end
	end

	/////////////////////////  Word sequencing  ////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			has_cmd  <= 1'b0;
			cmd      <= '0;
			word_cnt <= '0;
			o_att    <= '0;
			o_cfg    <= '{
				width:     video_cfg_pkg::dim_t'(DEFAULT_WIDTH),
				height:    video_cfg_pkg::dim_t'(DEFAULT_HEIGHT),
				vset:      '0,
				fb_en:     1'b0,
				fb_window: '0
			};
		end else if (!i_io_sel) begin
			// Next word after select rises is a command again
			has_cmd <= 1'b0;
		end else if (strobe) begin
			if (!has_cmd) begin
				has_cmd  <= 1'b1;
				cmd      <= i_io_din[video_cfg_pkg::CMD_W-1:0];
				word_cnt <= '0;
			end else begin
				// Saturate so long transfers do not wrap onto live words
				if (word_cnt != '1)
					word_cnt <= word_cnt + 1'b1;

				case (cmd)
					video_cfg_pkg::CMD_VIDEO_SIZE: begin
						// Porch and sync words are dropped
						if (word_cnt == 4'd0)
							o_cfg.width <= din_dim;
						if (word_cnt == 4'd4)
							o_cfg.height <= din_dim;
					end
					video_cfg_pkg::CMD_FB_WINDOW: begin
						case (word_cnt)
							4'd0: o_cfg.fb_en          <= i_io_din[15];
							4'd5: o_cfg.fb_window.hmin <= din_dim;
							4'd6: o_cfg.fb_window.hmax <= din_dim;
							4'd7: o_cfg.fb_window.vmin <= din_dim;
							4'd8: o_cfg.fb_window.vmax <= din_dim;
							default: ;
						endcase
					end
					video_cfg_pkg::CMD_VSET: begin
						o_cfg.vset <= din_dim;
					end
					video_cfg_pkg::CMD_VOLUME: begin
						o_att <= i_io_din[video_cfg_pkg::ATT_W-1:0];
					end
					// Unknown commands are acked and dropped
					default: ;
				endcase
			end
		end
	end

	/////////////////////////  Assertions  /////////////////////////////////

	// Ack never rises while the request is low
	a_ack_after_req: assert property (
		@(posedge clk) disable iff (resetd)
		$rose(o_io_ack) |-> i_io_req
	) else $error("ack rose while request was low");

	// Viewport restarts once per finished transfer
	a_update_pulse: assert property (
		@(posedge clk) disable iff (resetd)
		o_cfg_update |=> !o_cfg_update
	) else $error("cfg_update wider than one cycle");

endmodule

// ==== video_cfg_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Shared widths, command codes and typedefs for the video configuration
// path and the audio mixers.
// Window and configuration structs passed between decoder and viewport.
// Viewport FSM states.
////////////////////////////////////////////////////////////////////////////

package video_cfg_pkg;

	// Field widths
	localparam int WORD_W   = 16;
	localparam int CMD_W    = 8;
	localparam int DIM_W    = 12;
	localparam int ASPECT_W = 8;
	localparam int SAMPLE_W = 16;
	localparam int ATT_W    = 5;

	// Host bus word and command byte
	typedef logic [WORD_W-1:0]   word_t;
	typedef logic [CMD_W-1:0]    cmd_t;

	// Pixel or line count
	typedef logic [DIM_W-1:0]    dim_t;

	// One term of ARX:ARY
	typedef logic [ASPECT_W-1:0] aspect_t;

	typedef logic [SAMPLE_W-1:0] sample_t;

	// Bit 4 mutes, bits 3:0 are the shift amount
	typedef logic [ATT_W-1:0]    att_t;

	////////////////////////  Command codes  ///////////////////////////////

	typedef enum logic [CMD_W-1:0] {
		CMD_VIDEO_SIZE = 8'h20,
		CMD_VOLUME     = 8'h26,
		CMD_VSET       = 8'h27,
		CMD_FB_WINDOW  = 8'h2F
	} cmd_code_e;

	////////////////////////  Video structs  ///////////////////////////////

	// Display window, inclusive bounds
	typedef struct packed {
		dim_t hmin;
		dim_t hmax;
		dim_t vmin;
		dim_t vmax;
	} view_window_t;

	// Decoder registers seen by the viewport calculator
	typedef struct packed {
		dim_t         width;
		dim_t         height;
		dim_t         vset;
		logic         fb_en;
		view_window_t fb_window;
	} video_cfg_t;

	// Viewport FSM
	typedef enum logic [2:0] {
		IDLE,
		DIV_W,
		DIV_H,
		CLIP,
		PLACE
	} calc_state_e;

endpackage
